/* logic/fconv_pkg.sv */
package fconv_pkg;

    localparam int word_w = 32;
    localparam int addr_w = 4;
    localparam int strb_w = word_w / 8;

    // register map, byte offsets.
    localparam logic [addr_w-1:0] reg_operand = 4'h0; // write launches a conversion.
    localparam logic [addr_w-1:0] reg_ctrl    = 4'h4; // bit 0 selects the opcode.
    localparam logic [addr_w-1:0] reg_result  = 4'h8;
    localparam logic [addr_w-1:0] reg_status  = 4'hC;

    localparam logic [1:0] resp_okay = 2'b00;

    // status word layout.
    localparam int stat_busy_bit    = 0;
    localparam int stat_inexact_bit = 1;
    localparam int stat_invalid_bit = 2;
    localparam int stat_count_lsb   = 8;
    localparam int stat_count_w     = 8;

    // single precision exponent landmarks.
    localparam logic [7:0] exp_bias    = 8'd127;
    localparam logic [7:0] int_exp_max = 8'd158; // bias plus 31, first value outside int range.
    localparam logic [7:0] exp_max     = 8'hFF;  // inf and nan.

    localparam logic [word_w-1:0] int_max = 32'h7FFF_FFFF;
    localparam logic [word_w-1:0] int_min = 32'h8000_0000;

    typedef enum logic {
        op_itof = 1'b0,
        op_ftoi = 1'b1
    } conv_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] man;
    } fp_fields_t;

    // the same operand word seen as an integer or as float fields.
    typedef union packed {
        logic signed [word_w-1:0] raw;
        fp_fields_t               fp;
    } fp_word_u;

    typedef struct packed {
        conv_op_e op;
        fp_word_u operand;
    } conv_req_t;

    typedef struct packed {
        fp_word_u result;
        logic     inexact; // bits lost in rounding or truncation.
        logic     invalid; // nan or out of range on float to int.
    } conv_rsp_t;

endpackage

/* logic/itof.sv */
`timescale 1ns/1ps
`default_nettype none

module itof (
    input  fconv_pkg::fp_word_u x,
    output fconv_pkg::fp_word_u res,
    output logic                inexact
);

    logic [31:0]            mag;
    logic [31:0]            norm;
    logic [4:0]             lz;
    logic                   is_zero;
    logic                   rnd;
    logic [23:0]            man_sum;
    logic [7:0]             exp_v;
    fconv_pkg::fp_fields_t  f;

    assign mag = x.raw[31] ? ~x.raw + 32'd1 : x.raw; // -2^31 stays 0x80000000.
    assign is_zero = ~|mag;

    // leading zero count, the highest set bit wins.
    always_comb begin
        lz = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                lz = 5'(31 - i);
            end
        end
    end

    assign norm = mag << lz; // leading one lands on bit 31.
    assign rnd  = norm[7];   // first dropped bit only.

    // carry out of the 23 bit mantissa moves into the exponent.
    assign man_sum = {1'b0, norm[30:8]} + {23'b0, rnd};
    assign exp_v   = fconv_pkg::int_exp_max - {3'b0, lz} + {7'b0, man_sum[23]};

    always_comb begin
        f.sign = ~is_zero & x.raw[31];
        f.exp  = is_zero ? 8'd0 : exp_v;
        f.man  = man_sum[22:0]; // zero input leaves norm clear.
    end

    assign res.fp  = f;
    assign inexact = |norm[7:0];

endmodule

`default_nettype wire

/* logic/ftoi.sv */
`timescale 1ns/1ps
`default_nettype none

module ftoi (
    input  fconv_pkg::fp_word_u x,
    output fconv_pkg::fp_word_u res,
    output logic                inexact,
    output logic                invalid
);

    logic [23:0] sig;
    logic [4:0]  shamt;
    logic [54:0] wide;
    logic [31:0] mag;
    logic        is_nan;
    logic        is_min;

    assign sig   = {1'b1, x.fp.man}; // hidden one restored.
    assign shamt = 5'(x.fp.exp - fconv_pkg::exp_bias);

    // integer part sits above bit 23, fraction below.
    assign wide = {31'b0, sig} << shamt;
    assign mag  = wide[54:23];

    assign is_nan = (x.fp.exp == fconv_pkg::exp_max) && (x.fp.man != 23'd0);

    // -2^31 is the one value at the limit exponent that still fits.
    assign is_min = x.fp.sign && (x.fp.exp == fconv_pkg::int_exp_max) &&
                    (x.fp.man == 23'd0);

    always_comb begin
        res.raw = '0;
        inexact = 1'b0;
        invalid = 1'b0;
        if (is_nan) begin
            res.raw = fconv_pkg::int_max;
            invalid = 1'b1;
        end else if (is_min) begin
            res.raw = fconv_pkg::int_min;
        end else if (x.fp.exp >= fconv_pkg::int_exp_max) begin
            // saturate, covers inf too.
            res.raw = x.fp.sign ? fconv_pkg::int_min : fconv_pkg::int_max;
            invalid = 1'b1;
        end else if (x.fp.exp >= fconv_pkg::exp_bias) begin
            res.raw = x.fp.sign ? ~mag + 32'd1 : mag; // truncated toward zero.
            inexact = |wide[22:0];
        end else begin
            // magnitude below one; exp zero is zero or a denormal taken as zero.
            inexact = x.fp.exp != 8'd0;
        end
    end

endmodule

`default_nettype wire

/* logic/fconv_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fconv_pipe (
    input  logic                 clk,
    input  logic                 rst_n,
    input  fconv_pkg::conv_req_t req,
    input  logic                 req_valid,
    output fconv_pkg::conv_rsp_t rsp,
    output logic                 rsp_valid,
    output logic                 busy
);

    fconv_pkg::conv_req_t s1_req;
    logic                 s1_valid;
    fconv_pkg::conv_rsp_t s2_rsp;
    logic                 s2_valid;
    fconv_pkg::fp_word_u  itof_res;
    fconv_pkg::fp_word_u  ftoi_res;
    logic                 itof_inexact;
    logic                 ftoi_inexact;
    logic                 ftoi_invalid;
    fconv_pkg::conv_rsp_t conv_out;

    // both converters see the same word, each decodes it its own way.
    itof itof_i (
        .x       (s1_req.operand),
        .res     (itof_res),
        .inexact (itof_inexact)
    );

    ftoi ftoi_i (
        .x       (s1_req.operand),
        .res     (ftoi_res),
        .inexact (ftoi_inexact),
        .invalid (ftoi_invalid)
    );

    always_comb begin
        if (s1_req.op == fconv_pkg::op_ftoi) begin
            conv_out.result  = ftoi_res;
            conv_out.inexact = ftoi_inexact;
            conv_out.invalid = ftoi_invalid;
        end else begin
            conv_out.result  = itof_res;
            conv_out.inexact = itof_inexact;
            conv_out.invalid = 1'b0; // every integer has a float.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_req <= req;
        end
        if (s1_valid) begin
            s2_rsp <= conv_out;
        end
    end

    assign rsp       = s2_rsp;
    assign rsp_valid = s2_valid;
    assign busy      = s1_valid | s2_valid; // anything in flight.

endmodule

`default_nettype wire

/* logic/fconv_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fconv_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [fconv_pkg::addr_w-1:0]     awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [fconv_pkg::word_w-1:0]     wdata,
    input  logic [fconv_pkg::strb_w-1:0]     wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [fconv_pkg::addr_w-1:0]     araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [fconv_pkg::word_w-1:0]     rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output fconv_pkg::conv_req_t             req,
    output logic                             req_valid,
    input  fconv_pkg::conv_rsp_t             rsp,
    input  logic                             rsp_valid,
    input  logic                             busy
);

    logic                               wr_rdy;
    logic                               wr_fire;
    logic                               ar_fire;
    logic                               rd_pend;
    logic                               rd_req;
    logic                               rd_stall;
    logic [fconv_pkg::addr_w-1:0]       rd_addr;
    logic [fconv_pkg::addr_w-1:0]       rd_sel;
    logic [fconv_pkg::word_w-1:0]       operand_q;
    logic [fconv_pkg::word_w-1:0]       wr_word;
    logic [fconv_pkg::word_w-1:0]       rd_word;
    fconv_pkg::conv_op_e                op_q;
    fconv_pkg::fp_word_u                result_q;
    logic                               inexact_q;
    logic                               invalid_q;
    logic [fconv_pkg::stat_count_w-1:0] count_q;

    // write channel.
    assign awready = wr_rdy; // aw and w accepted together.
    assign wready  = wr_rdy;
    assign bresp   = fconv_pkg::resp_okay;
    assign wr_fire = wr_rdy & awvalid & wvalid;

    assign req_valid = wr_fire && (awaddr == fconv_pkg::reg_operand);

    // operand bytes merged under the write strobes.
    always_comb begin
        wr_word = operand_q;
        for (int b = 0; b < fconv_pkg::strb_w; b++) begin
            if (wstrb[b]) begin
                wr_word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        req.op      = op_q;
        req.operand = fconv_pkg::fp_word_u'(wr_word);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_rdy <= 1'b0;
            bvalid <= 1'b0;
            op_q   <= fconv_pkg::op_itof;
        end else begin
            wr_rdy <= awvalid && wvalid && !wr_rdy && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire && (awaddr == fconv_pkg::reg_ctrl) && wstrb[0]) begin
                op_q <= fconv_pkg::conv_op_e'(wdata[0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            operand_q <= wr_word;
        end
    end

    // last response and status.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q  <= '0;
            inexact_q <= 1'b0;
            invalid_q <= 1'b0;
            count_q   <= '0;
        end else if (rsp_valid) begin
            result_q  <= rsp.result;
            inexact_q <= rsp.inexact;
            invalid_q <= rsp.invalid;
            count_q   <= count_q + 1'b1; // wraps at 256.
        end
    end

    // read channel.
    assign rresp   = fconv_pkg::resp_okay;
    assign ar_fire = arready & arvalid;
    assign rd_sel  = ar_fire ? araddr : rd_addr;
    assign rd_req  = ar_fire | rd_pend;

    // a result read waits until nothing is in flight, including a launch this cycle.
    assign rd_stall = (rd_sel == fconv_pkg::reg_result) && (busy || req_valid);

    always_comb begin
        rd_word = '0;
        case (rd_sel)
            fconv_pkg::reg_operand: rd_word = operand_q;
            fconv_pkg::reg_ctrl:    rd_word[0] = op_q;
            fconv_pkg::reg_result:  rd_word = result_q.raw;
            fconv_pkg::reg_status: begin
                rd_word[fconv_pkg::stat_busy_bit]    = busy;
                rd_word[fconv_pkg::stat_inexact_bit] = inexact_q;
                rd_word[fconv_pkg::stat_invalid_bit] = invalid_q;
                rd_word[fconv_pkg::stat_count_lsb +: fconv_pkg::stat_count_w] = count_q;
            end
            default: rd_word = '0; // unmapped reads as zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rd_pend && !rvalid;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_req && !rd_stall) begin
                rvalid  <= 1'b1;
                rd_pend <= 1'b0;
            end else if (ar_fire) begin
                rd_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr <= araddr;
        end
        if (rd_req && !rd_stall) begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* logic/fconv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fconv_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [fconv_pkg::addr_w-1:0] awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [fconv_pkg::word_w-1:0] wdata,
    input  logic [fconv_pkg::strb_w-1:0] wstrb,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  logic [fconv_pkg::addr_w-1:0] araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output logic [fconv_pkg::word_w-1:0] rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready
);

    fconv_pkg::conv_req_t req;
    logic                 req_valid;
    fconv_pkg::conv_rsp_t rsp;
    logic                 rsp_valid;
    logic                 busy;

    fconv_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .busy      (busy)
    );

    fconv_pipe pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .busy      (busy)
    );

endmodule

`default_nettype wire

/* test/fconv_chk.sv */
`timescale 1ns/1ps

module fconv_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        arready,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        req_valid,
    input logic        rsp_valid,
    input logic        busy
);

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    // two cycle latency in both directions.
    rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> ##2 rsp_valid)
        else $error("rsp_valid missing two cycles after req_valid");

    rsp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> $past(req_valid, 2))
        else $error("rsp_valid without a request two cycles before");

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !(awready || arready || bvalid || rvalid || req_valid || rsp_valid || busy))
        else $error("handshake or valid high right after reset");

endmodule

bind fconv_top fconv_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .awready   (awready),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .busy      (busy)
);

/* test/fconv_tb.sv */
`timescale 1ns/1ps

module fconv_tb;

    localparam int cycle_ns = 20;
    localparam int n_vecs = 16;
    localparam int n_rt = 32;
    localparam int cycles_per_conv = 40; // two writes and two reads with margin.
    localparam int n_convs = n_vecs + 2 * n_rt + 2;
    localparam int limit_ns = (n_convs + 10) * cycles_per_conv * cycle_ns;

    typedef struct packed {
        fconv_pkg::conv_op_e op;
        logic [31:0]         operand;
        logic [31:0]         result;
        logic [1:0]          flags; // bit 1 invalid, bit 0 inexact.
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    int          n_checks = 0;
    int          n_err = 0;
    int          conv_count = 0;
    logic [31:0] lfsr_state = 32'd90;

    vec_t vecs [n_vecs] = '{
        '{fconv_pkg::op_itof, 32'h0000_0000, 32'h0000_0000, 2'b00},
        '{fconv_pkg::op_itof, 32'h0000_0001, 32'h3F80_0000, 2'b00},
        '{fconv_pkg::op_itof, 32'hFFFF_FFFF, 32'hBF80_0000, 2'b00},
        '{fconv_pkg::op_itof, 32'h7FFF_FFFF, 32'h4F00_0000, 2'b01}, // carry into exponent.
        '{fconv_pkg::op_itof, 32'h8000_0000, 32'hCF00_0000, 2'b00},
        '{fconv_pkg::op_itof, 32'h0100_0001, 32'h4B80_0001, 2'b01}, // 2^24 + 1.
        '{fconv_pkg::op_itof, 32'hFDFF_FFFE, 32'hCC00_0001, 2'b01}, // tie, away from zero.
        '{fconv_pkg::op_ftoi, 32'h3FC0_0000, 32'h0000_0001, 2'b01},
        '{fconv_pkg::op_ftoi, 32'hC030_0000, 32'hFFFF_FFFE, 2'b01},
        '{fconv_pkg::op_ftoi, 32'h3ECC_CCCD, 32'h0000_0000, 2'b01},
        '{fconv_pkg::op_ftoi, 32'h0000_0001, 32'h0000_0000, 2'b00}, // denormal.
        '{fconv_pkg::op_ftoi, 32'h4F00_0000, 32'h7FFF_FFFF, 2'b10},
        '{fconv_pkg::op_ftoi, 32'hCF00_0000, 32'h8000_0000, 2'b00},
        '{fconv_pkg::op_ftoi, 32'h7F80_0000, 32'h7FFF_FFFF, 2'b10},
        '{fconv_pkg::op_ftoi, 32'hFF80_0000, 32'h8000_0000, 2'b10},
        '{fconv_pkg::op_ftoi, 32'h7FC0_0000, 32'h7FFF_FFFF, 2'b10}
    };

    fconv_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        clk = 1'b0;
        forever #(cycle_ns / 2) clk = ~clk;
    end

    initial begin
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_err++;
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_eq("wready beside awready", 32'(wready), 32'd1);
        @(negedge clk); // accepted on the edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        check_eq("bresp", 32'(bresp), 32'd0);
        @(negedge clk); // bvalid left waiting one cycle.
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        check_eq("rresp", 32'(rresp), 32'd0);
        @(negedge clk); // rvalid left waiting one cycle.
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic run_conv(input fconv_pkg::conv_op_e op, input logic [31:0] operand,
                            output logic [31:0] result, output logic [1:0] flags);
        logic [31:0] st;
        axi_write(fconv_pkg::reg_ctrl, 32'(op));
        axi_write(fconv_pkg::reg_operand, operand);
        axi_read(fconv_pkg::reg_result, result);
        axi_read(fconv_pkg::reg_status, st);
        flags = {st[fconv_pkg::stat_invalid_bit], st[fconv_pkg::stat_inexact_bit]};
        conv_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s finished: %0d errors", name, n_err - errs_before);
    endtask

    initial begin
        int          errs_before;
        logic [31:0] res;
        logic [31:0] fval;
        logic [31:0] ival;
        logic [31:0] st;
        logic [1:0]  flg;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs_before = n_err;
        for (int i = 0; i < n_vecs; i++) begin
            run_conv(vecs[i].op, vecs[i].operand, res, flg);
            check_eq($sformatf("vec %0d result", i), res, vecs[i].result);
            check_eq($sformatf("vec %0d flags", i), 32'(flg), 32'(vecs[i].flags));
        end
        report_test("table", errs_before);

        errs_before = n_err;
        for (int n = 0; n < n_rt; n++) begin
            ival = rand_bits(24); // fits the 24 bit significand exactly.
            if (rand_bits(1) != 32'd0) begin
                ival = -ival;
            end
            run_conv(fconv_pkg::op_itof, ival, fval, flg);
            check_eq($sformatf("round trip %0d itof flags", n), 32'(flg), 32'd0);
            run_conv(fconv_pkg::op_ftoi, fval, res, flg);
            check_eq($sformatf("round trip %0d value", n), res, ival);
            check_eq($sformatf("round trip %0d ftoi flags", n), 32'(flg), 32'd0);
        end
        report_test("round_trip", errs_before);

        errs_before = n_err;
        run_conv(fconv_pkg::op_itof, 32'd7, res, flg);
        check_eq("itof of 7", res, 32'h40E0_0000);
        // result read accepted in the same cycle as the operand write.
        fork
            axi_write(fconv_pkg::reg_operand, 32'd9);
            axi_read(fconv_pkg::reg_result, res);
        join
        conv_count++;
        check_eq("result read beside operand write", res, 32'h4110_0000);
        report_test("back_pressure", errs_before);

        errs_before = n_err;
        axi_write(fconv_pkg::reg_ctrl, 32'd1);
        axi_read(fconv_pkg::reg_ctrl, st);
        check_eq("opcode readback ftoi", st, 32'd1);
        axi_write(fconv_pkg::reg_ctrl, 32'd0);
        axi_read(fconv_pkg::reg_ctrl, st);
        check_eq("opcode readback itof", st, 32'd0);
        axi_read(fconv_pkg::reg_status, st);
        check_eq("status count", 32'(st[15:8]), 32'(conv_count % 256));
        check_eq("status busy", 32'(st[fconv_pkg::stat_busy_bit]), 32'd0);
        report_test("status", errs_before);

        $display("checks %0d, errors %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/fconv_pkg.sv
logic/itof.sv
logic/ftoi.sv
logic/fconv_pipe.sv
logic/fconv_regs.sv
logic/fconv_top.sv
test/fconv_chk.sv
test/fconv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fconv testbench with verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fconv_tb -f flist.f -o fconv_sim

./obj_dir/fconv_sim | tee "$log"

if grep -q "STATUS: FAIL" "$log" || ! grep -q "STATUS: PASS" "$log"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
